/* verilog/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Address of the first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// Data and address width
`define CORE_XLEN 32

// Architectural register count and index width
`define CORE_NUM_REGS 32
`define CORE_REG_AW 5

// Size of one instruction word in bytes
`define CORE_INSN_BYTES 4

`endif

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Major opcodes, standard RV32 encodings
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // Sequencer states
    typedef enum logic [2:0] {
        ST_FETCH_SETUP  = 3'd0,
        ST_FETCH_ACCESS = 3'd1,
        ST_EXECUTE      = 3'd2,
        ST_MEM_SETUP    = 3'd3,  // Only for lw and sw
        ST_MEM_ACCESS   = 3'd4
    } lsu_state_e;

endpackage

`default_nettype wire

/* verilog/core_decode_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

interface core_decode_if;

    core_pkg::opcode_e       opcode;
    logic [2:0]              funct3;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    reg_write_en;  // Already masked for rd == x0
    logic [`CORE_XLEN-1:0]   imm;
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;

    modport idu (
        output opcode, funct3, rd, reg_write_en, imm, pc, rs1_data, rs2_data
    );

    modport exu (
        input opcode, funct3, imm, pc, rs1_data, rs2_data
    );

    // Sequencer only needs the memory class and the store data
    modport seq (
        input opcode, rs2_data
    );

endinterface

`default_nettype wire

/* verilog/core_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CORE_REG_AW-1:0] rs1_addr,
    input  logic [`CORE_REG_AW-1:0] rs2_addr,
    output logic [`CORE_XLEN-1:0]   rs1_data,
    output logic [`CORE_XLEN-1:0]   rs2_data,
    input  logic                    wen,
    input  logic [`CORE_REG_AW-1:0] rd_addr,
    input  logic [`CORE_XLEN-1:0]   rd_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd_addr != '0)) begin  // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* verilog/core_idu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_idu (
    input  logic [`CORE_XLEN-1:0]   instr,
    input  logic [`CORE_XLEN-1:0]   pc,
    output logic [`CORE_REG_AW-1:0] rs1_addr,
    output logic [`CORE_REG_AW-1:0] rs2_addr,
    input  logic [`CORE_XLEN-1:0]   rs1_data,
    input  logic [`CORE_XLEN-1:0]   rs2_data,
    core_decode_if.idu              dec
);

    core_pkg::opcode_e       opcode;
    logic [2:0]              funct3;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`CORE_XLEN-1:0]   imm;
    logic                    legal;
    logic                    writes;

    assign opcode   = core_pkg::opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        legal  = 1'b0;
        writes = 1'b0;
        imm    = '0;
        case (opcode)
            core_pkg::OP_LUI,
            core_pkg::OP_AUIPC: begin
                legal  = 1'b1;
                writes = 1'b1;
                imm    = imm_u;
            end
            core_pkg::OP_JAL: begin
                legal  = 1'b1;
                writes = 1'b1;
                imm    = imm_j;
            end
            core_pkg::OP_JALR,
            core_pkg::OP_IMM: begin
                legal  = (funct3 == 3'b000);  // jalr and addi only
                writes = 1'b1;
                imm    = imm_i;
            end
            core_pkg::OP_LOAD: begin
                legal  = (funct3 == 3'b010);  // lw only
                writes = 1'b1;
                imm    = imm_i;
            end
            core_pkg::OP_STORE: begin
                legal = (funct3 == 3'b010);
                imm   = imm_s;
            end
            core_pkg::OP_BRANCH: begin
                legal = (funct3 == 3'b000);   // beq only
                imm   = imm_b;
            end
            default: ;
        endcase
    end

    // Unsupported forms go downstream as an opcode outside the enum, i.e. a no-op
    assign dec.opcode       = legal ? opcode : core_pkg::opcode_e'(7'b0000000);
    assign dec.funct3       = funct3;
    assign dec.rd           = rd;
    assign dec.reg_write_en = legal && writes && (rd != '0);
    assign dec.imm          = imm;
    assign dec.pc           = pc;
    assign dec.rs1_data     = rs1_data;
    assign dec.rs2_data     = rs2_data;

endmodule

`default_nettype wire

/* verilog/core_exu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_exu (
    core_decode_if.exu            dec,
    input  logic [`CORE_XLEN-1:0] mem_rdata,
    output logic [`CORE_XLEN-1:0] result,
    output logic [`CORE_XLEN-1:0] mem_addr,
    output logic [`CORE_XLEN-1:0] next_pc
);

    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_branch;
    logic                  branch_taken;
    logic [`CORE_XLEN-1:0] alu_a;
    logic [`CORE_XLEN-1:0] alu_out;
    logic [`CORE_XLEN-1:0] link_pc;
    logic [`CORE_XLEN-1:0] pc_rel;
    logic [`CORE_XLEN-1:0] jalr_target;

    assign is_jal    = (dec.opcode == core_pkg::OP_JAL);
    assign is_jalr   = (dec.opcode == core_pkg::OP_JALR) && (dec.funct3 == 3'b000);
    assign is_branch = (dec.opcode == core_pkg::OP_BRANCH) && (dec.funct3 == 3'b000);

    // Operand A select
    always_comb begin
        case (dec.opcode)
            core_pkg::OP_AUIPC,
            core_pkg::OP_JAL:   alu_a = dec.pc;
            core_pkg::OP_LUI:   alu_a = '0;
            default:            alu_a = dec.rs1_data;
        endcase
    end

    assign alu_out     = alu_a + dec.imm;
    assign link_pc     = dec.pc + `CORE_INSN_BYTES;
    assign pc_rel      = dec.pc + dec.imm;      // jal and beq target
    assign jalr_target = {alu_out[`CORE_XLEN-1:1], 1'b0};

    assign branch_taken = is_branch && (dec.rs1_data == dec.rs2_data);

    always_comb begin
        case (dec.opcode)
            core_pkg::OP_JAL,
            core_pkg::OP_JALR: result = link_pc;
            core_pkg::OP_LOAD: result = mem_rdata;
            default:           result = alu_out;
        endcase
    end

    assign mem_addr = alu_out;  // rs1 + imm for lw and sw

    assign next_pc = is_jal       ? pc_rel :
                     is_jalr      ? jalr_target :
                     branch_taken ? pc_rel :
                     link_pc;

endmodule

`default_nettype wire

/* verilog/core_lsu_fsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_lsu_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    core_decode_if.seq              dec,
    input  logic [`CORE_XLEN-1:0]   result,
    input  logic [`CORE_XLEN-1:0]   mem_addr,
    input  logic [`CORE_XLEN-1:0]   next_pc,
    input  logic                    wen_dec,
    output logic [`CORE_XLEN-1:0]   instr,
    output logic [`CORE_XLEN-1:0]   pc,
    output logic [`CORE_XLEN-1:0]   mem_rdata,
    output logic                    rf_wen,
    output logic                    commit_valid,
    output logic [`CORE_XLEN-1:0]   commit_pc,
    output logic [`CORE_REG_AW-1:0] commit_rd,
    output logic                    commit_wen,
    output logic [`CORE_XLEN-1:0]   commit_data,
    output logic [`CORE_XLEN-1:0]   paddr,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output logic [`CORE_XLEN-1:0]   pwdata,
    input  logic [`CORE_XLEN-1:0]   prdata,
    input  logic                    pready
);

    core_pkg::lsu_state_e  state;
    core_pkg::lsu_state_e  state_next;
    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] ir_q;
    logic                  is_mem;
    logic                  in_mem;
    logic                  commit;

    assign is_mem = (dec.opcode == core_pkg::OP_LOAD) || (dec.opcode == core_pkg::OP_STORE);
    assign in_mem = (state == core_pkg::ST_MEM_SETUP) || (state == core_pkg::ST_MEM_ACCESS);

    // Retire in execute, or when the data transfer completes
    assign commit = ((state == core_pkg::ST_EXECUTE) && !is_mem) ||
                    ((state == core_pkg::ST_MEM_ACCESS) && pready);

    always_comb begin
        state_next = state;
        case (state)
            core_pkg::ST_FETCH_SETUP:  state_next = core_pkg::ST_FETCH_ACCESS;
            core_pkg::ST_FETCH_ACCESS: begin
                if (pready) begin
                    state_next = core_pkg::ST_EXECUTE;
                end
            end
            core_pkg::ST_EXECUTE: begin
                state_next = is_mem ? core_pkg::ST_MEM_SETUP : core_pkg::ST_FETCH_SETUP;
            end
            core_pkg::ST_MEM_SETUP:    state_next = core_pkg::ST_MEM_ACCESS;
            core_pkg::ST_MEM_ACCESS: begin
                if (pready) begin
                    state_next = core_pkg::ST_FETCH_SETUP;
                end
            end
            default:                   state_next = core_pkg::ST_FETCH_SETUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= core_pkg::ST_FETCH_SETUP;
            pc_q  <= `CORE_RESET_PC;
        end else begin
            state <= state_next;
            if (commit) begin
                pc_q <= next_pc;
            end
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if ((state == core_pkg::ST_FETCH_ACCESS) && pready) begin
            ir_q <= prdata;
        end
    end

    assign instr     = ir_q;
    assign pc        = pc_q;
    assign mem_rdata = prdata;  // lw result is taken in the completing cycle

    // APB master, all fields decoded from registered state
    assign psel    = (state != core_pkg::ST_EXECUTE);
    assign penable = (state == core_pkg::ST_FETCH_ACCESS) || (state == core_pkg::ST_MEM_ACCESS);
    assign paddr   = in_mem ? mem_addr : pc_q;
    assign pwrite  = in_mem && (dec.opcode == core_pkg::OP_STORE);
    assign pwdata  = pwrite ? dec.rs2_data : '0;

    assign rf_wen       = commit && wen_dec;
    assign commit_valid = commit;
    assign commit_pc    = pc_q;
    assign commit_rd    = ir_q[11:7];
    assign commit_wen   = rf_wen;
    assign commit_data  = result;

endmodule

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_top (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [`CORE_XLEN-1:0]   paddr,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output logic [`CORE_XLEN-1:0]   pwdata,
    input  logic [`CORE_XLEN-1:0]   prdata,
    input  logic                    pready,
    output logic                    commit_valid,
    output logic [`CORE_XLEN-1:0]   commit_pc,
    output logic [`CORE_REG_AW-1:0] commit_rd,
    output logic                    commit_wen,
    output logic [`CORE_XLEN-1:0]   commit_data
);

    logic [`CORE_XLEN-1:0]   instr;
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;
    logic [`CORE_XLEN-1:0]   result;
    logic [`CORE_XLEN-1:0]   mem_addr;
    logic [`CORE_XLEN-1:0]   mem_rdata;
    logic [`CORE_XLEN-1:0]   next_pc;
    logic                    rf_wen;

    core_decode_if dec_if ();

    core_lsu_fsm u_lsu_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec_if.seq),
        .result       (result),
        .mem_addr     (mem_addr),
        .next_pc      (next_pc),
        .wen_dec      (dec_if.reg_write_en),
        .instr        (instr),
        .pc           (pc),
        .mem_rdata    (mem_rdata),
        .rf_wen       (rf_wen),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_wen   (commit_wen),
        .commit_data  (commit_data),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready)
    );

    core_idu u_idu (
        .instr    (instr),
        .pc       (pc),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec_if.idu)
    );

    core_exu u_exu (
        .dec       (dec_if.exu),
        .mem_rdata (mem_rdata),
        .result    (result),
        .mem_addr  (mem_addr),
        .next_pc   (next_pc)
    );

    core_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (rf_wen),
        .rd_addr  (dec_if.rd),
        .rd_data  (result)
    );

endmodule

`default_nettype wire

/* testbench/core_properties.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic [`CORE_XLEN-1:0] paddr,
    input logic                  psel,
    input logic                  penable,
    input logic                  pwrite,
    input logic [`CORE_XLEN-1:0] pwdata,
    input logic                  pready,
    input logic                  commit_valid,
    input core_pkg::lsu_state_e  state
);

    int n_fails = 0;

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
        else begin
            $error("penable high without psel");
            n_fails++;
        end

    // Transfer fields hold through setup and wait states
    a_apb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && !pready) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else begin
            $error("APB address or data changed before pready");
            n_fails++;
        end

    a_commit_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |=> !commit_valid)
        else begin
            $error("commit_valid high for two cycles");
            n_fails++;
        end

    // FSM stalls in the access phase until pready
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && !pready) |=> $stable(state))
        else begin
            $error("FSM left an access phase without pready");
            n_fails++;
        end

    // First cycle out of reset is the fetch setup at the reset PC
    a_first_fetch: assert property (@(posedge clk)
        $rose(rst_n) |-> (psel && !penable && !commit_valid && paddr == `CORE_RESET_PC))
        else begin
            $error("first cycle after reset is not a fetch setup");
            n_fails++;
        end

endmodule

`default_nettype wire

/* testbench/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSNS    = 2000;
    localparam int MEM_WORDS    = 256;
    localparam int NUM_CATS     = 6;
    localparam logic [31:0] DATA_BASE = 32'h0000_0400;
    localparam logic [31:0] LFSR_SEED = 32'h8788_b7ac;

    logic                    clk;
    logic                    rst_n;
    logic [`CORE_XLEN-1:0]   paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`CORE_XLEN-1:0]   pwdata;
    logic [`CORE_XLEN-1:0]   prdata;
    logic                    pready;
    logic                    commit_valid;
    logic [`CORE_XLEN-1:0]   commit_pc;
    logic [`CORE_REG_AW-1:0] commit_rd;
    logic                    commit_wen;
    logic [`CORE_XLEN-1:0]   commit_data;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];          // Slave copy
    logic [31:0] model_dmem [MEM_WORDS];
    logic [31:0] model_x [`CORE_NUM_REGS];
    logic [31:0] model_pc;
    logic [31:0] lfsr;
    logic [1:0]  waits_left;
    logic [1:0]  wait_draw;
    logic        fetch_due;                 // Next completed transfer is a fetch
    int          commits;
    int          last_cat;
    int          n_checks [NUM_CATS];
    int          n_errors [NUM_CATS];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    core_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_wen   (commit_wen),
        .commit_data  (commit_data)
    );

    bind core_top core_properties u_props (
        .clk          (clk),
        .rst_n        (rst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .pready       (pready),
        .commit_valid (commit_valid),
        .state        (u_lsu_fsm.state)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input int k);
        logic [31:0] a;
        a = DATA_BASE + 32'(k * 4);
        return a ^ {~a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_beq(input logic [31:0] off, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic string cat_name(input int c);
        case (c)
            0:       return "reset fetch";
            1:       return "lui auipc addi";
            2:       return "jal jalr";
            3:       return "beq";
            4:       return "lw sw";
            default: return "unknown encodings";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp,
                           input logic [31:0] act, input int cat);
        n_checks[cat]++;
        if (exp !== act) begin
            n_errors[cat]++;
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // x31 holds the data base and x30 the jalr base; random writes avoid both
    task automatic build_program();
        int          i;
        int          t;
        logic [31:0] r;
        logic [31:0] off;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  kind;
        imem[0] = {12'h400, 5'd0, 3'b000, 5'd31, 7'b0010011};
        imem[MEM_WORDS-1] = enc_jal(32'(-(MEM_WORDS - 1) * 4), 5'd0);  // Wrap to 0
        i = 1;
        while (i < MEM_WORDS - 1) begin
            kind = 4'(rand_bits(4));
            rd   = 5'(rand_bits(5) % 30);
            rs1  = 5'(rand_bits(5));
            rs2  = rand_bits(1) ? rs1 : 5'(rand_bits(5));
            t    = int'(rand_bits(8));
            if (t == i) begin
                t = i + 1;
            end
            off = 32'((t - i) * 4);
            case (kind)
                4'd5, 4'd6: begin
                    r = rand_bits(20);
                    imem[i] = {r[19:0], rd, kind == 4'd5 ? 7'b0110111 : 7'b0010111};
                end
                4'd7, 4'd8: begin
                    r = rand_bits(8);
                    imem[i] = {2'b00, r[7:0], 2'b00, 5'd31, 3'b010, rd, 7'b0000011};
                end
                4'd9, 4'd10: begin
                    r = rand_bits(8);
                    imem[i] = {2'b00, r[7:3], rs2, 5'd31, 3'b010, r[2:0], 2'b00, 7'b0100011};
                end
                4'd11, 4'd12: imem[i] = enc_beq(off, rs1, rs2);
                4'd13:        imem[i] = enc_jal(off, rd);
                4'd14: begin
                    if (i < MEM_WORDS - 2) begin
                        if (t == i + 1) begin
                            t = i + 2;  // jalr must not target itself
                        end
                        imem[i] = {2'b00, 8'(t), 2'b00, 5'd0, 3'b000, 5'd30, 7'b0010011};
                        i++;
                        imem[i] = {11'd0, rand_bits(1) == 1, 5'd30, 3'b000, rd, 7'b1100111};
                    end else begin
                        imem[i] = 32'h0000_0013;
                    end
                end
                4'd15: begin
                    r = rand_bits(25);
                    imem[i] = {r[24:0], 7'b0110011};
                end
                default: begin
                    r = rand_bits(12);
                    imem[i] = {r[11:0], rs1, 3'b000, rd, 7'b0010011};
                end
            endcase
            i++;
        end
    endtask

    // Architectural model, run once per commit
    task automatic retire();
        logic [31:0] w;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [31:0] val;
        logic [31:0] npc;
        logic [4:0]  rd;
        logic        wr;
        int          cat;
        w     = imem[model_pc[9:2]];
        rd    = w[11:7];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        npc   = model_pc + 4;
        wr    = 1'b0;
        val   = '0;
        cat   = 5;
        case ({w[14:12], w[6:0]})
            {w[14:12], 7'b0110111}, {w[14:12], 7'b0010111}: begin
                wr  = 1'b1;
                val = {w[31:12], 12'b0} + (w[5] ? 32'd0 : model_pc);
                cat = 1;
            end
            {3'b000, 7'b0010011}: begin
                wr  = 1'b1;
                val = model_x[w[19:15]] + imm_i;
                cat = 1;
            end
            {w[14:12], 7'b1101111}, {3'b000, 7'b1100111}: begin
                wr  = 1'b1;
                val = model_pc + 4;
                npc = w[3] ? model_pc + imm_j : (model_x[w[19:15]] + imm_i) & ~32'd1;
                cat = 2;
            end
            {3'b000, 7'b1100011}: begin
                if (model_x[w[19:15]] == model_x[w[24:20]]) begin
                    npc = model_pc + imm_b;
                end
                cat = 3;
            end
            {3'b010, 7'b0000011}, {3'b010, 7'b0100011}: begin
                cat  = 4;
                addr = model_x[w[19:15]] + (w[5] ? imm_s : imm_i);
                compare("paddr", addr, paddr, cat);
                compare("pwrite", w[5], pwrite, cat);
                if (w[5]) begin
                    compare("pwdata", model_x[w[24:20]], pwdata, cat);
                    model_dmem[addr[9:2]] = model_x[w[24:20]];
                end else begin
                    wr  = 1'b1;
                    val = model_dmem[addr[9:2]];
                end
            end
            default: ;
        endcase
        compare("commit_pc", model_pc, commit_pc, cat);
        compare("commit_wen", wr && rd != 0, commit_wen, cat);
        if (wr && rd != 0) begin
            compare("commit_rd", rd, commit_rd, cat);
            compare("commit_data", val, commit_data, cat);
            model_x[rd] = val;
        end
        model_pc = npc;
        last_cat = cat;
        fetch_due = 1'b1;
        commits++;
    endtask

    // APB slave with 0 to 3 wait states per transfer
    always @(posedge clk) begin
        if (!rst_n) begin
            pready     <= 1'b0;
            waits_left <= '0;
        end else if (psel && !penable) begin
            wait_draw = 2'(rand_bits(2));
            waits_left <= wait_draw;
            if (wait_draw == 0) begin
                pready <= 1'b1;
                prdata <= paddr[10] ? dmem[paddr[9:2]] : imem[paddr[9:2]];
            end
        end else if (psel && penable && !pready) begin
            waits_left <= waits_left - 1;
            if (waits_left == 1) begin
                pready <= 1'b1;
                prdata <= paddr[10] ? dmem[paddr[9:2]] : imem[paddr[9:2]];
            end
        end else begin
            if (psel && penable && pwrite && paddr[10]) begin
                dmem[paddr[9:2]] <= pwdata;
            end
            pready <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (commit_valid) begin
                if (fetch_due) begin
                    n_errors[last_cat]++;
                    $display("ERROR: commit at %0t ns before its fetch completed", $time);
                end
                retire();
            end else if (psel && penable && pready && fetch_due) begin
                compare("paddr", model_pc, paddr, last_cat);
                compare("pwrite", 32'd0, pwrite, last_cat);
                fetch_due = 1'b0;
            end
        end
    end

    initial begin
        #((RESET_CYCLES + NUM_INSNS * 12) * CLK_PERIOD);
        $display("ERROR: timeout with %0d of %0d instructions retired", commits, NUM_INSNS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int total_checks;
        int total_errors;
        rst_n     = 1'b0;
        pready    = 1'b0;
        prdata    = '0;
        lfsr      = LFSR_SEED;
        model_pc  = `CORE_RESET_PC;
        fetch_due = 1'b1;
        commits   = 0;
        last_cat  = 0;
        for (int k = 0; k < NUM_CATS; k++) begin
            n_checks[k] = 0;
            n_errors[k] = 0;
        end
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k]       = 32'h0000_0013;
            dmem[k]       = fill_word(k);
            model_dmem[k] = fill_word(k);
        end
        for (int k = 0; k < `CORE_NUM_REGS; k++) begin
            model_x[k] = '0;
        end
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        wait (!fetch_due);
        $display("test %s: %0d checks, %0d errors", cat_name(0), n_checks[0], n_errors[0]);
        wait (commits >= NUM_INSNS);
        total_checks = n_checks[0];
        total_errors = n_errors[0];
        for (int k = 1; k < NUM_CATS; k++) begin
            $display("test %s: %0d checks, %0d errors", cat_name(k), n_checks[k], n_errors[k]);
            total_checks += n_checks[k];
            total_errors += n_errors[k];
        end
        $display("test assertions: %0d failures", DUT.u_props.n_fails);
        total_errors += DUT.u_props.n_fails;
        $display("%0d instructions, %0d checks, %0d errors", commits, total_checks,
                 total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/core_decode_if.sv
verilog/core_regfile.sv
verilog/core_idu.sv
verilog/core_exu.sv
verilog/core_lsu_fsm.sv
verilog/core_top.sv
testbench/core_properties.sv
testbench/core_tb.sv

/* Bender.yml */
package:
  name: core_rv32

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_pkg.sv
      - verilog/core_decode_if.sv
      - verilog/core_regfile.sv
      - verilog/core_idu.sv
      - verilog/core_exu.sv
      - verilog/core_lsu_fsm.sv
      - verilog/core_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/core_properties.sv
      - testbench/core_tb.sv
